/* build.f */
+incdir+rtl
rtl/cft_ucode_pkg.sv
rtl/cft_reg_pkg.sv
rtl/ucode_decoder.sv
rtl/reg_major.sv
rtl/reg_readout.sv
rtl/reg_board.sv
testbench/reg_board_tb.sv

/* testbench/reg_board_stimulus.txt */
# Hex columns: raddr waddr action ibus_in fp_sel | ibus_out ibus_oe fpd pc ac fz
# ibus_out and ibus_oe are read before the clock edge, fpd pc ac fz right after it
00 00 0 0000 0  0000 0 00 0000 0000 1
00 08 0 1234 0  0000 0 00 1234 0000 1
00 09 0 5678 1  0000 0 12 1234 0000 1
00 0a 0 9abc 2  0000 0 78 1234 9abc 0
00 0b 0 def0 3  0000 0 56 1234 9abc 0
08 00 0 0000 4  1234 1 bc 1234 9abc 0
09 00 0 0000 5  5678 1 9a 1234 9abc 0
0a 00 0 0000 6  9abc 1 f0 1234 9abc 0
0b 00 0 0000 7  def0 1 de 1234 9abc 0
03 00 0 0000 0  0000 0 34 1234 9abc 0
1f 00 0 0000 1  0000 0 12 1234 9abc 0
0a 0b 0 9abc 7  9abc 1 de 1234 9abc 0
0b 00 0 0000 6  9abc 1 bc 1234 9abc 0
00 08 0 ffff 0  0000 0 34 ffff 9abc 0
00 09 0 0000 0  0000 0 ff ffff 9abc 0
00 0a 0 0001 0  0000 0 ff ffff 0001 0
00 0b 0 ffff 0  0000 0 ff ffff 0001 0
08 00 8 0000 0  ffff 1 ff 0000 0001 0
09 00 b 0000 2  0000 1 00 0000 0001 0
09 00 a 0000 3  ffff 1 ff 0000 0001 0
0a 00 d 0000 4  0001 1 01 0000 0000 1
0a 00 d 0000 5  0000 1 00 0000 ffff 0
0a 00 c 0000 4  ffff 1 ff 0000 0000 1
0a 00 c 0000 4  0000 1 00 0000 0001 0
0b 00 e 0000 6  ffff 1 ff 0000 0001 0
0b 00 f 0000 7  0000 1 00 0000 0001 0
0b 00 f 0000 6  ffff 1 ff 0000 0001 0
08 00 9 0000 0  0000 1 00 0000 0001 0
0a 00 7 0000 4  0001 1 01 0000 0001 0
0b 00 1 0000 6  fffe 1 fe 0000 0001 0
09 00 8 0000 7  0000 1 ff 0001 0001 0
0b 00 c 0000 0  fffe 1 01 0001 0002 0
09 00 e 0000 4  0000 1 02 0001 0002 0
0b 00 a 0000 7  ffff 1 ff 0001 0002 0
00 08 8 4000 0  0000 0 01 4000 0002 0
00 09 b 0100 2  0000 0 01 4000 0002 0
00 0a d 0000 4  0000 0 02 4000 0000 1
00 0b e 8000 7  0000 0 ff 4000 0000 1
00 0a c 7fff 5  0000 0 00 4000 7fff 0
09 00 0 0000 6  0100 1 00 4000 7fff 0
0a 09 8 00ff 1  7fff 1 40 4001 7fff 0
0a 0a 0 ffff 4  7fff 1 ff 4001 ffff 0
0a 00 c 0000 5  ffff 1 ff 4001 0000 1
00 00 c 0000 4  0000 0 00 4001 0001 0
00 00 d 0000 4  0000 0 01 4001 0000 1
00 0a 0 0080 4  0000 0 00 4001 0080 0
0b 0a 0 0000 3  8000 1 00 4001 0000 1
00 00 0 0000 7  0000 0 80 4001 0000 1

/* testbench/reg_board_tb.sv */
// Register board testbench

`default_nettype none
`timescale 1ns/1ps

`include "cft_defines.svh"

module reg_board_tb;

   import cft_ucode_pkg::*;
   import cft_reg_pkg::*;

   localparam int MAX_LINES   = 1000;      // Stimulus file length limit
   localparam int RESET_LIMIT = 20;        // Cycles allowed for reset release
   localparam int SIM_LIMIT   = 40000;     // Overall run limit in ns

   ////////////////////////////////////////////////////////////
   // DUT signals
   ////////////////////////////////////////////////////////////

   logic                  clk;
   logic                  rst_n;
   ucode_reg_e            raddr;
   ucode_reg_e            waddr;
   action_e               action;
   word_t                 ibus_in;
   fp_sel_e               fp_sel;
   word_t                 ibus_out;
   logic                  ibus_oe;
   logic [`CFT_FPD_W-1:0] fpd;
   word_t                 pc;
   word_t                 ac;
   logic                  fz;

   int errors;                             // Mismatches and other failures
   int steps;                              // File steps replayed

   logic [31:0] fields [0:10];             // Five inputs, six expected values

   reg_board UUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .raddr    (raddr),
      .waddr    (waddr),
      .action   (action),
      .ibus_in  (ibus_in),
      .fp_sel   (fp_sel),
      .ibus_out (ibus_out),
      .ibus_oe  (ibus_oe),
      .fpd      (fpd),
      .pc       (pc),
      .ac       (ac),
      .fz       (fz)
   );

   ////////////////////////////////////////////////////////////
   // Clock, reset and run limit
   ////////////////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;               // 8 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n <= 1'b1;                       // Released on a falling edge
   end

   initial begin
      #(SIM_LIMIT);
      $display("Simulation ran past its time limit");
      $display("test failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected) begin
         errors++;
         $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   // Ends on a falling edge
   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < RESET_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (rst_n !== 1'b1) begin
         errors++;
         $display("Reset was not released within %0d cycles", RESET_LIMIT);
      end
   endtask

   // Bus checked before the rising edge and registered results just after it
   task automatic run_step();
      raddr   = ucode_reg_e'(fields[0][`CFT_ADDR_W-1:0]);
      waddr   = ucode_reg_e'(fields[1][`CFT_ADDR_W-1:0]);
      action  = action_e'(fields[2][`CFT_ACTION_W-1:0]);
      ibus_in = fields[3][`CFT_WORD_W-1:0];
      fp_sel  = fp_sel_e'(fields[4][2:0]);
      #2;
      compare_value("ibus_out", fields[5], ibus_out);
      compare_value("ibus_oe", fields[6], ibus_oe);
      @(posedge clk);
      @(negedge clk);
      compare_value("fpd", fields[7], fpd);
      compare_value("pc", fields[8], pc);
      compare_value("ac", fields[9], ac);
      compare_value("fz", fields[10], fz);
   endtask

   // Idle cycles hold every register and leave fp_sel alone
   task automatic idle_gap();
      int unsigned gap;
      gap = $urandom % 3;
      repeat (gap) begin
         raddr  = UR_NONE;
         waddr  = UR_NONE;
         action = ACT_IDLE;
         @(posedge clk);
         @(negedge clk);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus replay
   ////////////////////////////////////////////////////////////

   initial begin
      int          fd;
      int          n;
      int          lines;
      string       line;
      errors  = 0;
      steps   = 0;
      lines   = 0;
      raddr   = UR_NONE;
      waddr   = UR_NONE;
      action  = ACT_IDLE;
      ibus_in = '0;
      fp_sel  = FP_PC_LO;
      void'($urandom(32'h17de_f339));
      wait_reset_release();
      fd = $fopen("testbench/reg_board_stimulus.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Could not open the stimulus file");
      end else begin
         while (!$feof(fd) && lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            lines++;
            if (line.len() == 0 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        fields[0], fields[1], fields[2], fields[3],
                        fields[4], fields[5], fields[6], fields[7],
                        fields[8], fields[9], fields[10]);
            if (n <= 0) continue;          // Blank line
            if (n != 11) begin
               errors++;
               $display("Stimulus line %0d has %0d fields instead of 11", lines, n);
               continue;
            end
            run_step();
            steps++;
            idle_gap();
         end
         if (!$feof(fd)) begin
            errors++;
            $display("Stimulus file is longer than %0d lines", MAX_LINES);
         end
         $fclose(fd);
      end
      if (steps == 0) begin
         errors++;
         $display("No stimulus steps were replayed");
      end
      $display("Steps replayed: %0d, errors: %0d", steps, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/reg_board.sv */
// Register board top level

`default_nettype none
`timescale 1ns/1ps

`include "cft_defines.svh"

module reg_board (
   input  logic                      clk,
   input  logic                      rst_n,
   input  cft_ucode_pkg::ucode_reg_e raddr,     // Microcode read address
   input  cft_ucode_pkg::ucode_reg_e waddr,     // Microcode write address
   input  cft_ucode_pkg::action_e    action,    // Microcode action
   input  cft_reg_pkg::word_t        ibus_in,   // Processor bus in
   input  cft_reg_pkg::fp_sel_e      fp_sel,    // Front-panel byte choice
   output cft_reg_pkg::word_t        ibus_out,  // Processor bus out
   output logic                      ibus_oe,   // Bus output enable
   output logic [`CFT_FPD_W-1:0]     fpd,       // Front-panel byte
   output cft_reg_pkg::word_t        pc,        // Program counter to the machine
   output cft_reg_pkg::word_t        ac,        // Accumulator to the ALU
   output logic                      fz         // Accumulator zero flag
);

   import cft_reg_pkg::*;

   ////////////////////////////////////////////////////////////
   // Local signals
   ////////////////////////////////////////////////////////////

   word_t      dr;                         // Only seen through the readout
   word_t      sp;
   logic [3:0] rd_sel;

   logic       wr_pc, wr_dr, wr_ac, wr_sp;
   logic       inc_pc, inc_dr, inc_ac, inc_sp;
   logic       dec_dr, dec_ac, dec_sp;

   ////////////////////////////////////////////////////////////
   // Decoder
   ////////////////////////////////////////////////////////////

   ucode_decoder u_decoder (
      .raddr  (raddr),
      .waddr  (waddr),
      .action (action),
      .rd_sel (rd_sel),
      .wr_pc  (wr_pc),
      .wr_dr  (wr_dr),
      .wr_ac  (wr_ac),
      .wr_sp  (wr_sp),
      .inc_pc (inc_pc),
      .inc_dr (inc_dr),
      .inc_ac (inc_ac),
      .inc_sp (inc_sp),
      .dec_dr (dec_dr),
      .dec_ac (dec_ac),
      .dec_sp (dec_sp)
   );

   ////////////////////////////////////////////////////////////
   // Major registers
   ////////////////////////////////////////////////////////////

   // PC counts up only
   reg_major reg_pc (
      .clk (clk), .rst_n (rst_n), .ibus_in (ibus_in),
      .wr  (wr_pc), .inc (inc_pc), .dec (1'b0),
      .q   (pc), .zero ()
   );

   reg_major reg_dr (
      .clk (clk), .rst_n (rst_n), .ibus_in (ibus_in),
      .wr  (wr_dr), .inc (inc_dr), .dec (dec_dr),
      .q   (dr), .zero ()
   );

   // AC also supplies the zero flag
   reg_major reg_ac (
      .clk (clk), .rst_n (rst_n), .ibus_in (ibus_in),
      .wr  (wr_ac), .inc (inc_ac), .dec (dec_ac),
      .q   (ac), .zero (fz)
   );

   reg_major reg_sp (
      .clk (clk), .rst_n (rst_n), .ibus_in (ibus_in),
      .wr  (wr_sp), .inc (inc_sp), .dec (dec_sp),
      .q   (sp), .zero ()
   );

   ////////////////////////////////////////////////////////////
   // Readout
   ////////////////////////////////////////////////////////////

   reg_readout u_readout (
      .clk      (clk),
      .rst_n    (rst_n),
      .pc       (pc),
      .dr       (dr),
      .ac       (ac),
      .sp       (sp),
      .rd_sel   (rd_sel),
      .fp_sel   (fp_sel),
      .ibus_out (ibus_out),
      .ibus_oe  (ibus_oe),
      .fpd      (fpd)
   );

endmodule

`default_nettype wire

/* rtl/reg_readout.sv */
// Bus and front-panel readout

`default_nettype none
`timescale 1ns/1ps

`include "cft_defines.svh"

module reg_readout (
   input  logic                  clk,
   input  logic                  rst_n,
   input  cft_reg_pkg::word_t    pc,
   input  cft_reg_pkg::word_t    dr,
   input  cft_reg_pkg::word_t    ac,
   input  cft_reg_pkg::word_t    sp,
   input  logic [3:0]            rd_sel,    // One-hot or zero
   input  cft_reg_pkg::fp_sel_e  fp_sel,    // Front-panel byte choice
   output cft_reg_pkg::word_t    ibus_out,  // Processor bus output
   output logic                  ibus_oe,   // Bus output enable
   output logic [`CFT_FPD_W-1:0] fpd        // Front-panel byte
);

   import cft_reg_pkg::*;

   ////////////////////////////////////////////////////////////
   // Processor bus
   ////////////////////////////////////////////////////////////

   // AND-OR mux, zero when nothing is selected
   assign ibus_out = ({`CFT_WORD_W{rd_sel[RI_PC]}} & pc)
                   | ({`CFT_WORD_W{rd_sel[RI_DR]}} & dr)
                   | ({`CFT_WORD_W{rd_sel[RI_AC]}} & ac)
                   | ({`CFT_WORD_W{rd_sel[RI_SP]}} & sp);

   assign ibus_oe = |rd_sel;               // Any register driving

   ////////////////////////////////////////////////////////////
   // Front panel
   ////////////////////////////////////////////////////////////

   logic [`CFT_FPD_W-1:0] fp_byte;

   always_comb begin
      case (fp_sel)
         FP_PC_LO: fp_byte = pc[`CFT_FPD_W-1:0];
         FP_PC_HI: fp_byte = pc[`CFT_WORD_W-1:`CFT_FPD_W];
         FP_DR_LO: fp_byte = dr[`CFT_FPD_W-1:0];
         FP_DR_HI: fp_byte = dr[`CFT_WORD_W-1:`CFT_FPD_W];
         FP_AC_LO: fp_byte = ac[`CFT_FPD_W-1:0];
         FP_AC_HI: fp_byte = ac[`CFT_WORD_W-1:`CFT_FPD_W];
         FP_SP_LO: fp_byte = sp[`CFT_FPD_W-1:0];
         default:  fp_byte = sp[`CFT_WORD_W-1:`CFT_FPD_W];  // SP high
      endcase
   end

   // Panel sees the byte one cycle late
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fpd <= '0;
      end else begin
         fpd <= fp_byte;
      end
   end

endmodule

`default_nettype wire

/* rtl/reg_major.sv */
// Major register

`default_nettype none
`timescale 1ns/1ps

module reg_major (
   input  logic               clk,
   input  logic               rst_n,
   input  cft_reg_pkg::word_t ibus_in,   // Processor bus input
   input  logic               wr,        // Load from the bus
   input  logic               inc,       // Count up
   input  logic               dec,       // Count down
   output cft_reg_pkg::word_t q,         // Stored value
   output logic               zero       // Stored value is zero
);

   import cft_reg_pkg::*;

   ////////////////////////////////////////////////////////////
   // Next value
   ////////////////////////////////////////////////////////////

   word_t q_next;

   // Bus load beats the action strobes
   always_comb begin
      q_next = q;                          // Hold by default
      if (wr) begin
         q_next = ibus_in;
      end else if (inc) begin
         q_next = q + 1'b1;                // Wraps past 16'hffff
      end else if (dec) begin
         q_next = q - 1'b1;                // Wraps below zero
      end
   end

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         q <= '0;
      end else begin
         q <= q_next;
      end
   end

   assign zero = (q == '0);               // Straight off the register

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // The decoder never asks for both directions at once
   a_inc_dec_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(inc && dec)
   ) else $error("inc and dec together");

endmodule

`default_nettype wire

/* rtl/ucode_decoder.sv */
// Microcode field decoder

`default_nettype none
`timescale 1ns/1ps

module ucode_decoder (
   input  cft_ucode_pkg::ucode_reg_e raddr,   // Register to drive onto the bus
   input  cft_ucode_pkg::ucode_reg_e waddr,   // Register to load from the bus
   input  cft_ucode_pkg::action_e    action,  // Increment or decrement request
   output logic [3:0]                rd_sel,  // One-hot read select
   output logic                      wr_pc,
   output logic                      wr_dr,
   output logic                      wr_ac,
   output logic                      wr_sp,
   output logic                      inc_pc,
   output logic                      inc_dr,
   output logic                      inc_ac,
   output logic                      inc_sp,
   output logic                      dec_dr,
   output logic                      dec_ac,
   output logic                      dec_sp
);

   import cft_ucode_pkg::*;
   import cft_reg_pkg::*;

   ////////////////////////////////////////////////////////////
   // Read address
   ////////////////////////////////////////////////////////////

   always_comb begin
      rd_sel = 4'b0000;                    // Codes outside 8..11 read nothing
      case (raddr)
         UR_PC:   rd_sel[RI_PC] = 1'b1;
         UR_DR:   rd_sel[RI_DR] = 1'b1;
         UR_AC:   rd_sel[RI_AC] = 1'b1;
         UR_SP:   rd_sel[RI_SP] = 1'b1;
         default: rd_sel = 4'b0000;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Write address
   ////////////////////////////////////////////////////////////

   always_comb begin
      wr_pc = 1'b0;
      wr_dr = 1'b0;
      wr_ac = 1'b0;
      wr_sp = 1'b0;
      case (waddr)
         UR_PC:   wr_pc = 1'b1;
         UR_DR:   wr_dr = 1'b1;
         UR_AC:   wr_ac = 1'b1;
         UR_SP:   wr_sp = 1'b1;
         default: wr_pc = 1'b0;            // No register loads
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Action field
   ////////////////////////////////////////////////////////////

   // Each code drives exactly one strobe
   always_comb begin
      inc_pc = 1'b0;
      inc_dr = 1'b0;
      inc_ac = 1'b0;
      inc_sp = 1'b0;
      dec_dr = 1'b0;
      dec_ac = 1'b0;
      dec_sp = 1'b0;
      case (action)
         ACT_INC_PC: inc_pc = 1'b1;
         ACT_INC_DR: inc_dr = 1'b1;
         ACT_DEC_DR: dec_dr = 1'b1;
         ACT_INC_AC: inc_ac = 1'b1;
         ACT_DEC_AC: dec_ac = 1'b1;
         ACT_INC_SP: inc_sp = 1'b1;
         ACT_DEC_SP: dec_sp = 1'b1;
         default:    inc_pc = 1'b0;        // Idle, code 9 included
      endcase
   end

   // The readout mux and the register datapaths rely on these
   always_comb begin
      a_rd_onehot: assert final ($onehot0(rd_sel))
         else $error("rd_sel not one-hot");
      a_act_onehot: assert final ($onehot0({inc_pc, inc_dr, inc_ac, inc_sp,
                                             dec_dr, dec_ac, dec_sp}))
         else $error("more than one action strobe");
   end

endmodule

`default_nettype wire

/* rtl/cft_reg_pkg.sv */
// Register board types

`default_nettype none

`include "cft_defines.svh"

package cft_reg_pkg;

   typedef logic [`CFT_WORD_W-1:0] word_t;  // One processor word

   // Bit position of each register in the read select
   typedef enum logic [1:0] {
      RI_PC = 2'd0,
      RI_DR = 2'd1,
      RI_AC = 2'd2,
      RI_SP = 2'd3
   } reg_idx_e;

   // Front-panel byte select, low byte on even codes
   typedef enum logic [2:0] {
      FP_PC_LO = 3'd0, FP_PC_HI = 3'd1,
      FP_DR_LO = 3'd2, FP_DR_HI = 3'd3,
      FP_AC_LO = 3'd4, FP_AC_HI = 3'd5,
      FP_SP_LO = 3'd6, FP_SP_HI = 3'd7
   } fp_sel_e;

endpackage

`default_nettype wire

/* rtl/cft_ucode_pkg.sv */
// Microcode field encodings

`default_nettype none

`include "cft_defines.svh"

package cft_ucode_pkg;

   ////////////////////////////////////////////////////////////
   // Read and write address field
   ////////////////////////////////////////////////////////////

   // Only codes 8 to 11 belong to this board
   typedef enum logic [`CFT_ADDR_W-1:0] {
      UR_NONE = 5'd0,                    // Nothing selected
      UR_PC   = 5'd8,                    // Program counter
      UR_DR   = 5'd9,                    // Data register
      UR_AC   = 5'd10,                   // Accumulator
      UR_SP   = 5'd11                    // Stack pointer
   } ucode_reg_e;

   ////////////////////////////////////////////////////////////
   // Action field
   ////////////////////////////////////////////////////////////

   typedef enum logic [`CFT_ACTION_W-1:0] {
      ACT_IDLE   = 4'd0,                 // Any unlisted code is idle too
      ACT_INC_PC = 4'd8,
      ACT_INC_DR = 4'd10,
      ACT_DEC_DR = 4'd11,
      ACT_INC_AC = 4'd12,
      ACT_DEC_AC = 4'd13,
      ACT_INC_SP = 4'd14,
      ACT_DEC_SP = 4'd15                 // No PC decrement exists
   } action_e;

endpackage

`default_nettype wire

/* rtl/cft_defines.svh */
// Register board widths

`ifndef CFT_DEFINES_SVH
`define CFT_DEFINES_SVH

////////////////////////////////////////////////////////////
// Processor word
////////////////////////////////////////////////////////////

`define CFT_WORD_W   16  // Data word and bus width

////////////////////////////////////////////////////////////
// Microcode fields and front panel
////////////////////////////////////////////////////////////

`define CFT_ADDR_W   5   // Read and write address fields
`define CFT_ACTION_W 4   // Action field
`define CFT_FPD_W    8   // Front-panel byte

`endif
